// ==== rtl/soc_bus_params.svh ====
`ifndef SOC_BUS_PARAMS_SVH
`define SOC_BUS_PARAMS_SVH

// ====================
// Address map
// ====================

// RAM is matched on address bits 31:24.
`define RAM_BASE_HI     8'h00
// Peripherals are matched on address bits 31:8.
`define GPIO_BASE       24'h1fd004
`define TICKER_BASE     24'h1fd005

// RAM geometry and wait states per access.
`define RAM_WORDS       1024
`define RAM_WAIT        2

// GPIO register offsets.
`define GPIO_OUT_OFS    8'h00
`define GPIO_IN_OFS     8'h04

// Ticker register offsets.
`define TICK_COUNT_OFS  8'h00
`define TICK_CMP_OFS    8'h04
`define TICK_STAT_OFS   8'h08

`endif

// ==== rtl/soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

    // ====================
    // Data types
    // ====================

    // One bus word.
    typedef logic [31:0] word_t;

    // Target selected by the address decoder.
    typedef enum logic [1:0] {
        REGION_RAM,
        REGION_GPIO,
        REGION_TICKER,
        REGION_NONE
    } region_e;

    // ====================
    // RAM access FSM
    // ====================

    typedef enum logic {
        RAM_IDLE,
        RAM_BUSY
    } ram_state_e;

endpackage

`default_nettype wire

// ==== rtl/slave_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface slave_bus_if import soc_bus_pkg::*; ();

    // Offset inside the slave window.
    logic [23:0] addr;
    word_t       wrdata;
    logic [3:0]  byteenable;
    logic        rd;
    logic        wr;
    word_t       rddata;

    modport decoder (
        output addr,
        output wrdata,
        output byteenable,
        output rd,
        output wr,
        input  rddata
    );

    modport slave (
        input  addr,
        input  wrdata,
        input  byteenable,
        input  rd,
        input  wr,
        output rddata
    );

endinterface

`default_nettype wire

// ==== rtl/dbus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_params.svh"

module dbus import soc_bus_pkg::*; (
    input  wire word_t       master_address_i,
    input  wire [3:0]        master_byteenable_i,
    input  wire              master_read_i,
    input  wire              master_write_i,
    input  wire word_t       master_wrdata_i,
    output word_t            master_rddata_o,
    output logic             master_stall_o,
    input  wire              ram_stall_i,
    slave_bus_if.decoder     ram_bus,
    slave_bus_if.decoder     gpio_bus,
    slave_bus_if.decoder     ticker_bus
);

    region_e region;

    // ====================
    // Request fan-out
    // ====================

    assign ram_bus.addr          = master_address_i[23:0];
    assign ram_bus.wrdata        = master_wrdata_i;
    assign ram_bus.byteenable    = master_byteenable_i;

    assign gpio_bus.addr         = master_address_i[23:0];
    assign gpio_bus.wrdata       = master_wrdata_i;
    assign gpio_bus.byteenable   = master_byteenable_i;

    assign ticker_bus.addr       = master_address_i[23:0];
    assign ticker_bus.wrdata     = master_wrdata_i;
    assign ticker_bus.byteenable = master_byteenable_i;

    // Priority decode with RAM first.
    always_comb begin
        if (master_address_i[31:24] == `RAM_BASE_HI) begin
            region = REGION_RAM;
        end else if (master_address_i[31:8] == `GPIO_BASE) begin
            region = REGION_GPIO;
        end else if (master_address_i[31:8] == `TICKER_BASE) begin
            region = REGION_TICKER;
        end else begin
            region = REGION_NONE;
        end
    end

    // ====================
    // Strobes and return
    // ====================

    always_comb begin
        ram_bus.rd      = 1'b0;
        ram_bus.wr      = 1'b0;
        gpio_bus.rd     = 1'b0;
        gpio_bus.wr     = 1'b0;
        ticker_bus.rd   = 1'b0;
        ticker_bus.wr   = 1'b0;
        master_rddata_o = '0;
        master_stall_o  = 1'b0;
        case (region)
            REGION_RAM: begin
                ram_bus.rd      = master_read_i;
                ram_bus.wr      = master_write_i;
                master_rddata_o = ram_bus.rddata;
                master_stall_o  = ram_stall_i;
            end
            REGION_GPIO: begin
                gpio_bus.rd     = master_read_i;
                gpio_bus.wr     = master_write_i;
                master_rddata_o = gpio_bus.rddata;
            end
            REGION_TICKER: begin
                ticker_bus.rd   = master_read_i;
                ticker_bus.wr   = master_write_i;
                master_rddata_o = ticker_bus.rddata;
            end
            default: begin
                // Unmapped space reads zero and drops writes.
                master_rddata_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/ram_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_params.svh"

module ram_slave import soc_bus_pkg::*; (
    input  wire          clk,
    input  wire          rst_i,
    slave_bus_if.slave   bus,
    output logic         stall_o
);

    localparam int IDX_W  = $clog2(`RAM_WORDS);
    localparam int WAIT_W = $clog2(`RAM_WAIT + 1);
    localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(`RAM_WAIT);

    word_t             mem [`RAM_WORDS];
    ram_state_e        state_q;
    logic [WAIT_W-1:0] wait_q;
    logic [IDX_W-1:0]  word_idx;
    logic              access;
    logic              done;

    initial begin
        for (int i = 0; i < `RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign access   = bus.rd | bus.wr;
    assign word_idx = bus.addr[IDX_W+1:2];

    // Last cycle of an access after all wait states.
    assign done    = (state_q == RAM_BUSY) && (wait_q == WAIT_LAST);
    assign stall_o = access && !done;

    // ====================
    // Wait-state FSM
    // ====================

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= RAM_IDLE;
            wait_q  <= '0;
        end else begin
            case (state_q)
                RAM_IDLE: begin
                    if (access) begin
                        state_q <= RAM_BUSY;
                        wait_q  <= WAIT_W'(1);
                    end
                end
                RAM_BUSY: begin
                    // Abandoned or finished access goes back to idle.
                    if (!access || done) begin
                        state_q <= RAM_IDLE;
                        wait_q  <= '0;
                    end else begin
                        wait_q  <= wait_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= RAM_IDLE;
                    wait_q  <= '0;
                end
            endcase
        end
    end

    // Byte merge on the completing cycle.
    always @(posedge clk) begin
        if (done && bus.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.byteenable[b]) begin
                    mem[word_idx][8*b +: 8] <= bus.wrdata[8*b +: 8];
                end
            end
        end
    end

    assign bus.rddata = mem[word_idx];

endmodule

`default_nettype wire

// ==== rtl/gpio_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_params.svh"

module gpio_slave import soc_bus_pkg::*; (
    input  wire          clk,
    input  wire          rst_i,
    slave_bus_if.slave   bus,
    input  wire word_t   gpio_in_i,
    output word_t        gpio_out_o
);

    word_t out_q;
    word_t in_meta_q;
    word_t in_sync_q;
    logic  sel_out;
    logic  sel_in;

    assign sel_out = (bus.addr[7:0] == `GPIO_OUT_OFS);
    assign sel_in  = (bus.addr[7:0] == `GPIO_IN_OFS);

    // Output register with byte writes.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_q <= '0;
        end else if (bus.wr && sel_out) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.byteenable[b]) begin
                    out_q[8*b +: 8] <= bus.wrdata[8*b +: 8];
                end
            end
        end
    end

    // Two-flop synchronizer for the pins.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            in_meta_q <= gpio_in_i;
            in_sync_q <= in_meta_q;
        end
    end

    always_comb begin
        bus.rddata = '0;
        if (bus.rd) begin
            if (sel_out) begin
                bus.rddata = out_q;
            end else if (sel_in) begin
                bus.rddata = in_sync_q;
            end
        end
    end

    assign gpio_out_o = out_q;

endmodule

`default_nettype wire

// ==== rtl/ticker_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_params.svh"

module ticker_slave import soc_bus_pkg::*; (
    input  wire          clk,
    input  wire          rst_i,
    slave_bus_if.slave   bus,
    output logic         irq_o
);

    word_t      count_q;
    word_t      cmp_q;
    logic       flag_q;
    logic [7:0] ofs;
    logic       wr_count;
    logic       wr_cmp;
    logic       wr_stat;

    assign ofs      = bus.addr[7:0];
    assign wr_count = bus.wr && (ofs == `TICK_COUNT_OFS);
    assign wr_cmp   = bus.wr && (ofs == `TICK_CMP_OFS);
    assign wr_stat  = bus.wr && (ofs == `TICK_STAT_OFS);

    // ====================
    // Counter and compare
    // ====================

    always_ff @(posedge clk) begin
        if (rst_i) begin
            count_q <= '0;
        end else if (wr_count) begin
            count_q <= bus.wrdata;
        end else begin
            count_q <= count_q + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cmp_q <= '0;
        end else if (wr_cmp) begin
            cmp_q <= bus.wrdata;
        end
    end

    // Sticky match; a new match wins over a clear in the same cycle.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            flag_q <= 1'b0;
        end else if (count_q == cmp_q) begin
            flag_q <= 1'b1;
        end else if (wr_stat) begin
            flag_q <= 1'b0;
        end
    end

    always_comb begin
        bus.rddata = '0;
        if (bus.rd) begin
            case (ofs)
                `TICK_COUNT_OFS: bus.rddata = count_q;
                `TICK_CMP_OFS:   bus.rddata = cmp_q;
                `TICK_STAT_OFS:  bus.rddata = {31'd0, flag_q};
                default:         bus.rddata = '0;
            endcase
        end
    end

    assign irq_o = flag_q;

endmodule

`default_nettype wire

// ==== rtl/soc_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top import soc_bus_pkg::*; (
    input  wire          clk,
    input  wire          rst_i,
    input  wire word_t   master_address_i,
    input  wire [3:0]    master_byteenable_i,
    input  wire          master_read_i,
    input  wire          master_write_i,
    input  wire word_t   master_wrdata_i,
    output word_t        master_rddata_o,
    output logic         master_stall_o,
    input  wire word_t   gpio_in_i,
    output word_t        gpio_out_o,
    output logic         ticker_irq_o
);

    logic ram_stall;

    slave_bus_if ram_bus ();
    slave_bus_if gpio_bus ();
    slave_bus_if ticker_bus ();

    dbus u_dbus (
        .master_address_i    (master_address_i),
        .master_byteenable_i (master_byteenable_i),
        .master_read_i       (master_read_i),
        .master_write_i      (master_write_i),
        .master_wrdata_i     (master_wrdata_i),
        .master_rddata_o     (master_rddata_o),
        .master_stall_o      (master_stall_o),
        .ram_stall_i         (ram_stall),
        .ram_bus             (ram_bus),
        .gpio_bus            (gpio_bus),
        .ticker_bus          (ticker_bus)
    );

    ram_slave u_ram (
        .clk     (clk),
        .rst_i   (rst_i),
        .bus     (ram_bus),
        .stall_o (ram_stall)
    );

    gpio_slave u_gpio (
        .clk        (clk),
        .rst_i      (rst_i),
        .bus        (gpio_bus),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o)
    );

    ticker_slave u_ticker (
        .clk   (clk),
        .rst_i (rst_i),
        .bus   (ticker_bus),
        .irq_o (ticker_irq_o)
    );

endmodule

`default_nettype wire

// ==== tests/soc_bus_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_bus_params.svh"

module soc_bus_tb import soc_bus_pkg::*; ();

    localparam int    TIMEOUT   = 64;
    localparam word_t RAM_WIN   = 32'h0000_0100;
    localparam word_t GPIO_OUT  = {`GPIO_BASE, `GPIO_OUT_OFS};
    localparam word_t GPIO_IN   = {`GPIO_BASE, `GPIO_IN_OFS};
    localparam word_t TICK_CNT  = {`TICKER_BASE, `TICK_COUNT_OFS};
    localparam word_t TICK_CMP  = {`TICKER_BASE, `TICK_CMP_OFS};
    localparam word_t TICK_STAT = {`TICKER_BASE, `TICK_STAT_OFS};

    logic       clk = 1'b0;
    logic       rst_i;
    word_t      address;
    logic [3:0] byteenable;
    logic       rd;
    logic       wr;
    word_t      wrdata;
    word_t      rddata;
    logic       stall;
    word_t      gpio_in;
    word_t      gpio_out;
    logic       irq;
    int         cyc = 0;

    // Reference model of the memory map.
    word_t ram_model [int];
    word_t gpio_out_model;
    word_t gpio_in_model;
    word_t tick_base;
    int    tick_base_cyc;
    word_t cmp_model;

    soc_bus_top dut (
        .clk                 (clk),
        .rst_i               (rst_i),
        .master_address_i    (address),
        .master_byteenable_i (byteenable),
        .master_read_i       (rd),
        .master_write_i      (wr),
        .master_wrdata_i     (wrdata),
        .master_rddata_o     (rddata),
        .master_stall_o      (stall),
        .gpio_in_i           (gpio_in),
        .gpio_out_o          (gpio_out),
        .ticker_irq_o        (irq)
    );

    always #50 clk = ~clk;

    // Rising edges seen so far.
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ====================
    // Model helpers
    // ====================

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, logic [3:0] en);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (en[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic word_t ram_expected(int idx);
        return ram_model.exists(idx) ? ram_model[idx] : '0;
    endfunction

    // Count seen at the falling edge of a given cycle.
    function automatic word_t predict_count(int at_cyc);
        return tick_base + word_t'(at_cyc - tick_base_cyc - 1);
    endfunction

    task automatic check_eq(input string name, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("MISMATCH %s: expected %08h, actual %08h", name, exp, act);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // ====================
    // Bus master
    // ====================

    task automatic bus_access(input word_t a, input logic is_wr, input logic [3:0] en,
                              input word_t d, input int exp_stalls,
                              output word_t rdat, output int done_cyc);
        logic done;
        int   stalls;
        int   t;
        @(posedge clk);
        address    <= a;
        byteenable <= en;
        wrdata     <= d;
        rd         <= !is_wr;
        wr         <= is_wr;
        done     = 1'b0;
        stalls   = 0;
        t        = 0;
        rdat     = '0;
        done_cyc = 0;
        while (!done && t < TIMEOUT) begin
            @(negedge clk);
            if (stall) begin
                stalls++;
            end else begin
                rdat     = rddata;
                done_cyc = cyc;
                done     = 1'b1;
            end
            t++;
        end
        assert (done) else begin
            $display("Timeout: stall never dropped for address %08h", a);
            $display("Test failed");
            $fatal(1);
        end
        check_eq("stall cycles", word_t'(exp_stalls), word_t'(stalls));
        @(posedge clk);
        rd <= 1'b0;
        wr <= 1'b0;
    endtask

    task automatic read_word(input word_t a, input int exp_stalls,
                             output word_t rdat, output int rc);
        bus_access(a, 1'b0, 4'hf, '0, exp_stalls, rdat, rc);
    endtask

    task automatic write_word(input word_t a, input logic [3:0] en, input word_t d,
                              input int exp_stalls, output int wc);
        word_t unused;
        bus_access(a, 1'b1, en, d, exp_stalls, unused, wc);
    endtask

    initial begin
        word_t      r;
        word_t      v;
        logic [3:0] en;
        int         idx;
        int         c;
        int         t;
        rst_i      = 1'b1;
        address    = '0;
        byteenable = '0;
        rd         = 1'b0;
        wr         = 1'b0;
        wrdata     = '0;
        gpio_in    = '0;
        void'($urandom(32'h534ecb06));
        gpio_out_model = '0;
        gpio_in_model  = '0;
        cmp_model      = '0;
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;

        // RAM traffic over a 16-word window.
        for (int i = 0; i < 80; i++) begin
            idx = $urandom_range(0, 15);
            if ($urandom_range(0, 1) == 1) begin
                en = 4'($urandom);
                v  = $urandom;
                write_word(RAM_WIN + word_t'(idx << 2), en, v, `RAM_WAIT, c);
                ram_model[idx] = merge_bytes(ram_expected(idx), v, en);
            end else begin
                read_word(RAM_WIN + word_t'(idx << 2), `RAM_WAIT, r, c);
                check_eq("ram read", ram_expected(idx), r);
            end
        end

        // GPIO output and synchronized input.
        for (int i = 0; i < 8; i++) begin
            en = 4'($urandom);
            v  = $urandom;
            write_word(GPIO_OUT, en, v, 0, c);
            gpio_out_model = merge_bytes(gpio_out_model, v, en);
            @(negedge clk);
            check_eq("gpio pins", gpio_out_model, gpio_out);
            read_word(GPIO_OUT, 0, r, c);
            check_eq("gpio out read", gpio_out_model, r);
            @(posedge clk);
            gpio_in_model = $urandom;
            gpio_in <= gpio_in_model;
            repeat (3) @(posedge clk);
            read_word(GPIO_IN, 0, r, c);
            check_eq("gpio in read", gpio_in_model, r);
        end

        // Ticker count load and free run.
        for (int i = 0; i < 6; i++) begin
            v = $urandom;
            write_word(TICK_CNT, 4'hf, v, 0, c);
            tick_base     = v;
            tick_base_cyc = c;
            repeat ($urandom_range(0, 20)) @(posedge clk);
            read_word(TICK_CNT, 0, r, c);
            check_eq("ticker count", predict_count(c), r);
        end

        // Compare match sets a sticky flag.
        cmp_model = predict_count(cyc) + 32'd24;
        write_word(TICK_CMP, 4'hf, cmp_model, 0, c);
        write_word(TICK_STAT, 4'hf, '0, 0, c);
        read_word(TICK_STAT, 0, r, c);
        check_eq("status before match", 32'd0, r);
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!irq && t < TIMEOUT);
        assert (irq) else begin
            $display("Timeout: ticker interrupt never raised");
            $display("Test failed");
            $fatal(1);
        end
        check_eq("count at match", cmp_model + 32'd1, predict_count(cyc));
        repeat ($urandom_range(2, 10)) @(posedge clk);
        read_word(TICK_STAT, 0, r, c);
        check_eq("status sticky", 32'd1, r);
        @(negedge clk);
        check_eq("irq sticky", 32'd1, word_t'(irq));
        write_word(TICK_STAT, 4'hf, $urandom, 0, c);
        @(negedge clk);
        check_eq("irq cleared", 32'd0, word_t'(irq));
        read_word(TICK_STAT, 0, r, c);
        check_eq("status cleared", 32'd0, r);

        // Unmapped space reads zero and drops writes.
        // Low address bits alias the RAM window and every register offset.
        for (int i = 0; i < 32; i++) begin
            v = {1'b1, 7'($urandom), RAM_WIN[23:0] + 24'((i % 16) << 2)};
            write_word(v, 4'hf, $urandom, 0, c);
            read_word(v, 0, r, c);
            check_eq("unmapped read", 32'd0, r);
        end
        for (int i = 0; i < 16; i++) begin
            read_word(RAM_WIN + word_t'(i << 2), `RAM_WAIT, r, c);
            check_eq("ram after unmapped", ram_expected(i), r);
        end
        read_word(GPIO_OUT, 0, r, c);
        check_eq("gpio after unmapped", gpio_out_model, r);
        read_word(GPIO_IN, 0, r, c);
        check_eq("gpio in after unmapped", gpio_in_model, r);
        read_word(TICK_CMP, 0, r, c);
        check_eq("compare after unmapped", cmp_model, r);
        read_word(TICK_CNT, 0, r, c);
        check_eq("count after unmapped", predict_count(c), r);
        read_word(TICK_STAT, 0, r, c);
        check_eq("status after unmapped", 32'd0, r);

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== soc_bus.f ====
+incdir+rtl
rtl/soc_bus_pkg.sv
rtl/slave_bus_if.sv
rtl/dbus.sv
rtl/ram_slave.sv
rtl/gpio_slave.sv
rtl/ticker_slave.sv
rtl/soc_bus_top.sv
tests/soc_bus_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = soc_bus_tb
FILELIST  = soc_bus.f
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
